// ==== compile.f ====
+incdir+logic
+incdir+verif
logic/instrDecPkg.sv
logic/opcodeMatch.sv
logic/ctrlStrobes.sv
logic/aluOpReg.sv
logic/instrDec.sv
verif/instrDecTb.sv

// ==== verif/instrDecModel.svh ====
`ifndef INSTRDECMODEL_SVH
`define INSTRDECMODEL_SVH

// ------------------------------
// Instruction set reference
// ------------------------------

localparam logic [127:0] modelMask = `ID_ENABLE_MASK;   // Same default mask as the DUT

// Opcode is part of the kept instruction set and its enable bit is set
function automatic logic opcodeEnabled(input logic [`ID_OPCODE_W-1:0] op);
    logic known;
    known = op inside {[0:12], 17, 18, 21, 22, 25, 26, [29:32], [35:37], [41:43],
                       [47:49], [62:79], 82, 83, [86:94]};
    return known && modelMask[op];
endfunction

// Strobe groups, each gated by the enable check
function automatic instrDecPkg::ctrl_t expectCtrl(input logic [`ID_OPCODE_W-1:0] op);
    instrDecPkg::ctrl_t result;
    result = '0;
    if (opcodeEnabled(op)) begin
        result.push  = op inside {1, 8, 11, 37, 43, 49, 70, 77};
        result.pop   = op inside {5, 6, 7, 9, 18, 22, 26, 30, 32, 63, 65, 67,
                                  72, 74, 79, 83, 87, 89, 91, 93};    // Stores, POP, S_ forms
        result.memWr = op inside {4, 5, 6, 7};
        result.ldi   = op inside {2, 3};
        result.sti   = op inside {6, 7};
        result.fft   = op inside {3, 7};    // Bit-reversed pair
        result.reqIn = op inside {10, 11};
        result.outEn = (op == 12);
    end
    return result;
endfunction

// ALU code table, zero for anything not listed
function automatic logic [`ID_ALUOP_W-1:0] expectAluOp(input logic [`ID_OPCODE_W-1:0] op);
    logic [`ID_ALUOP_W-1:0] code;
    case (op)
        0, 1, 2, 3, 5, 9: code = 1;         // Loads, SET_P and POP
        17, 18:           code = 2;
        21, 22:           code = 4;
        25, 26:           code = 6;
        29, 30:           code = 8;
        31, 32:           code = 9;
        35:               code = 11;
        36, 37:           code = 12;
        41:               code = 15;
        42, 43:           code = 16;
        47:               code = 19;
        48, 49:           code = 20;
        62, 63:           code = 29;
        64, 65:           code = 30;
        66, 67:           code = 31;
        68:               code = 32;
        69, 70:           code = 33;
        71, 72:           code = 34;
        73, 74:           code = 35;
        75:               code = 36;
        76, 77:           code = 37;
        78, 79:           code = 38;
        82, 83:           code = 40;
        86, 87:           code = 42;
        88, 89:           code = 43;
        90, 91:           code = 44;
        92, 93:           code = 45;
        default:          code = 0;         // Stores, PSH, I/O, NOP, unknown
    endcase
    if (!opcodeEnabled(op)) begin
        code = 0;
    end
    return code;
endfunction

`endif

// ==== verif/instrDecTb.sv ====
`default_nettype none
`include "instrDec_config.svh"

module instrDecTb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "instrDecModel.svh"

    localparam int resetCycles = 5;
    localparam int testCycles  = resetCycles + 2 + 128 + 2 * 128 + 12 + 4 + 400 + 3;
    localparam int cycleLimit  = testCycles + 50;       // Margin past the longest run

    logic                    clk;
    logic                    rstN;
    logic [`ID_OPCODE_W-1:0] opcode;
    logic                    push, pop, memWr, reqIn, outEn, ldi, sti, fft;
    instrDecPkg::aluOp_e     aluOp;
    instrDecPkg::ctrl_t      ctrlNow;                   // DUT strobes as one bus
    logic [`ID_ALUOP_W-1:0]  modelAluOp;                // Expected registered code
    string                   testName = "reset";
    int                      cycleCount = 0;
    integer                  seed = 66807;
    integer                  randWord;

    instrDec DUT (
        .clk (clk), .rstN (rstN), .opcode (opcode),
        .push (push), .pop (pop), .memWr (memWr), .reqIn (reqIn),
        .outEn (outEn), .ldi (ldi), .sti (sti), .fft (fft),
        .aluOp (aluOp)
    );

    assign ctrlNow = {push, pop, memWr, reqIn, outEn, ldi, sti, fft};

    always #20 clk = ~clk;                              // 40 ns period

    // ------------------------------
    // Checking
    // ------------------------------

    task automatic checkValue(input string what, input logic [7:0] expected,
                              input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s %s expected %0h actual %0h", testName, what, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Model register, one cycle behind the opcode
    always @(posedge clk) begin
        if (!rstN) begin
            modelAluOp <= '0;
        end else if (!(`ID_HOLD_ON_NOP && opcode == `ID_NOP_OPCODE && opcodeEnabled(opcode))) begin
            modelAluOp <= expectAluOp(opcode);
        end
    end

    always @(negedge clk) begin
        checkValue("strobes", expectCtrl(opcode), ctrlNow);    // Combinational path
        checkValue("aluOp", modelAluOp, aluOp);                // Registered path
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, stimulus did not finish", cycleCount);
            $display("Checks failed");
            $fatal(1, "Run stopped by cycle limit");
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic applyOpcode(input logic [`ID_OPCODE_W-1:0] op);
        @(posedge clk);
        opcode <= op;
    endtask

    initial begin
        clk    = 1'b0;
        rstN   = 1'b0;
        opcode = 7'd13;                                 // Jump slot, unknown here
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        repeat (2) applyOpcode(7'd13);                  // Outputs stay quiet after reset

        testName = "sweep";
        for (int op = 0; op < 128; op++) begin
            applyOpcode(op[`ID_OPCODE_W-1:0]);
        end

        testName = "strobe groups";
        for (int op = 0; op < 128; op++) begin
            if (expectCtrl(op[`ID_OPCODE_W-1:0]) != '0) begin
                applyOpcode(op[`ID_OPCODE_W-1:0]);
                applyOpcode(7'd13);                     // Strobes must drop again
            end
        end

        testName = "nop hold";
        applyOpcode(7'd17);                             // ADD
        repeat (3) applyOpcode(`ID_NOP_OPCODE);
        @(negedge clk);
        checkValue("aluOp held", 8'd2, aluOp);
        applyOpcode(7'd78);                             // LES replaces the held code
        repeat (2) applyOpcode(`ID_NOP_OPCODE);
        applyOpcode(7'd88);                             // SHL
        applyOpcode(`ID_NOP_OPCODE);
        applyOpcode(7'd13);
        applyOpcode(`ID_NOP_OPCODE);
        applyOpcode(7'd5);                              // SET_P

        testName = "reset mid run";
        applyOpcode(7'd92);                             // SRS, nonzero code before reset
        @(posedge clk);
        rstN <= 1'b0;                                   // Opcode stays on SRS
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        testName = "random";
        for (int i = 0; i < 400; i++) begin
            randWord = $random(seed);
            applyOpcode($unsigned(randWord) % 128);
        end

        applyOpcode(7'd13);
        repeat (2) @(posedge clk);                      // Let the last checks run
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/instrDec.sv ====
`default_nettype none
`include "instrDec_config.svh"

module instrDec (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire [`ID_OPCODE_W-1:0] opcode,
    output logic                   push,
    output logic                   pop,
    output logic                   memWr,
    output logic                   reqIn,
    output logic                   outEn,
    output logic                   ldi,
    output logic                   sti,
    output logic                   fft,
    output instrDecPkg::aluOp_e    aluOp    // Registered, one cycle after opcode
);

    instrDecPkg::decoded_t decoded;         // Shared by both back ends
    instrDecPkg::ctrl_t    ctrl;            // Same-cycle strobes

    // ------------------------------
    // Decode units
    // ------------------------------

    opcodeMatch uMatch (
        .opcode  (opcode),
        .decoded (decoded)
    );

    ctrlStrobes uStrobes (
        .decoded (decoded),
        .ctrl    (ctrl)
    );

    aluOpReg uAluOp (
        .clk     (clk),
        .rstN    (rstN),
        .decoded (decoded),
        .aluOp   (aluOp)
    );

    // Strobe bus split into the processor's control lines
    assign push  = ctrl.push;
    assign pop   = ctrl.pop;
    assign memWr = ctrl.memWr;
    assign reqIn = ctrl.reqIn;
    assign outEn = ctrl.outEn;
    assign ldi   = ctrl.ldi;
    assign sti   = ctrl.sti;
    assign fft   = ctrl.fft;

endmodule

`default_nettype wire

// ==== logic/aluOpReg.sv ====
`default_nettype none
`include "instrDec_config.svh"

module aluOpReg (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire instrDecPkg::decoded_t decoded,
    output instrDecPkg::aluOp_e        aluOp
);

    localparam bit holdOnNop = (`ID_HOLD_ON_NOP != 0);    // NOP keeps the last code

    instrDecPkg::aluOp_e aluNext;   // Code for the opcode at this edge

    // ------------------------------
    // Opcode to ALU code
    // ------------------------------

    always_comb begin
        case (decoded.op)
            // Loads and POP bring an operand into the accumulator
            instrDecPkg::LOD, instrDecPkg::P_LOD,
            instrDecPkg::LDI, instrDecPkg::ILI,
            instrDecPkg::SET_P, instrDecPkg::POP:
                aluNext = instrDecPkg::ALU_LOAD;
            instrDecPkg::ADD, instrDecPkg::S_ADD:
                aluNext = instrDecPkg::ALU_ADD;
            instrDecPkg::MLT, instrDecPkg::S_MLT:
                aluNext = instrDecPkg::ALU_MLT;
            instrDecPkg::DIV, instrDecPkg::S_DIV:
                aluNext = instrDecPkg::ALU_DIV;
            instrDecPkg::MOD, instrDecPkg::S_MOD:
                aluNext = instrDecPkg::ALU_MOD;
            instrDecPkg::SGN, instrDecPkg::S_SGN:
                aluNext = instrDecPkg::ALU_SGN;
            instrDecPkg::NEG:
                aluNext = instrDecPkg::ALU_NEG;             // Acts on accumulator
            instrDecPkg::NEG_M, instrDecPkg::P_NEG_M:
                aluNext = instrDecPkg::ALU_NEG_M;           // Acts on memory operand
            instrDecPkg::ABS:
                aluNext = instrDecPkg::ALU_ABS;
            instrDecPkg::ABS_M, instrDecPkg::P_ABS_M:
                aluNext = instrDecPkg::ALU_ABS_M;
            instrDecPkg::PST:
                aluNext = instrDecPkg::ALU_PST;
            instrDecPkg::PST_M, instrDecPkg::P_PST_M:
                aluNext = instrDecPkg::ALU_PST_M;
            instrDecPkg::AND, instrDecPkg::S_AND:
                aluNext = instrDecPkg::ALU_AND;
            instrDecPkg::ORR, instrDecPkg::S_ORR:
                aluNext = instrDecPkg::ALU_ORR;
            instrDecPkg::XOR, instrDecPkg::S_XOR:
                aluNext = instrDecPkg::ALU_XOR;
            instrDecPkg::INV:
                aluNext = instrDecPkg::ALU_INV;
            instrDecPkg::INV_M, instrDecPkg::P_INV_M:
                aluNext = instrDecPkg::ALU_INV_M;
            instrDecPkg::LAN, instrDecPkg::S_LAN:
                aluNext = instrDecPkg::ALU_LAN;
            instrDecPkg::LOR, instrDecPkg::S_LOR:
                aluNext = instrDecPkg::ALU_LOR;
            instrDecPkg::LIN:
                aluNext = instrDecPkg::ALU_LIN;
            instrDecPkg::LIN_M, instrDecPkg::P_LIN_M:
                aluNext = instrDecPkg::ALU_LIN_M;
            instrDecPkg::LES, instrDecPkg::S_LES:
                aluNext = instrDecPkg::ALU_LES;
            instrDecPkg::GRE, instrDecPkg::S_GRE:
                aluNext = instrDecPkg::ALU_GRE;
            instrDecPkg::EQU, instrDecPkg::S_EQU:
                aluNext = instrDecPkg::ALU_EQU;
            instrDecPkg::SHL, instrDecPkg::S_SHL:
                aluNext = instrDecPkg::ALU_SHL;
            instrDecPkg::SHR, instrDecPkg::S_SHR:
                aluNext = instrDecPkg::ALU_SHR;
            instrDecPkg::SRS, instrDecPkg::S_SRS:
                aluNext = instrDecPkg::ALU_SRS;
            default:
                aluNext = instrDecPkg::ALU_NONE;    // Stores, stack push, I/O and NOP
        endcase
        if (!decoded.valid) begin
            aluNext = instrDecPkg::ALU_NONE;        // Unknown or disabled opcode
        end
    end

    // ------------------------------
    // Pipeline register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rstN) begin
            aluOp <= instrDecPkg::ALU_NONE;
        end else if (!(holdOnNop && decoded.isNop)) begin
            aluOp <= aluNext;                       // One cycle behind the opcode
        end
    end

endmodule

`default_nettype wire

// ==== logic/ctrlStrobes.sv ====
`default_nettype none

module ctrlStrobes (
    input  wire instrDecPkg::decoded_t decoded,
    output instrDecPkg::ctrl_t         ctrl
);

    instrDecPkg::opcode_e op;   // Shorthand for the group tests

    assign op = decoded.op;

    // ------------------------------
    // Strobe groups
    // ------------------------------

    always_comb begin
        ctrl = '0;              // Unknown or disabled opcodes drive nothing
        if (decoded.valid) begin
            // Push variants save the accumulator before loading a new value
            ctrl.push  = op inside {instrDecPkg::P_LOD,   instrDecPkg::PSH,
                                    instrDecPkg::P_INN,   instrDecPkg::P_NEG_M,
                                    instrDecPkg::P_ABS_M, instrDecPkg::P_PST_M,
                                    instrDecPkg::P_INV_M, instrDecPkg::P_LIN_M};
            // Stack-operand forms consume the top of stack
            ctrl.pop   = op inside {instrDecPkg::SET_P, instrDecPkg::STI,
                                    instrDecPkg::ISI,   instrDecPkg::POP,
                                    instrDecPkg::S_ADD, instrDecPkg::S_MLT,
                                    instrDecPkg::S_DIV, instrDecPkg::S_MOD,
                                    instrDecPkg::S_SGN, instrDecPkg::S_AND,
                                    instrDecPkg::S_ORR, instrDecPkg::S_XOR,
                                    instrDecPkg::S_LAN, instrDecPkg::S_LOR,
                                    instrDecPkg::S_LES, instrDecPkg::S_GRE,
                                    instrDecPkg::S_EQU, instrDecPkg::S_SHL,
                                    instrDecPkg::S_SHR, instrDecPkg::S_SRS};
            ctrl.memWr = op inside {instrDecPkg::SET, instrDecPkg::SET_P,
                                    instrDecPkg::STI, instrDecPkg::ISI};   // All stores
            ctrl.ldi   = op inside {instrDecPkg::LDI, instrDecPkg::ILI};   // Indirect load
            ctrl.sti   = op inside {instrDecPkg::STI, instrDecPkg::ISI};   // Indirect store
            ctrl.fft   = op inside {instrDecPkg::ILI, instrDecPkg::ISI};   // Reversed address
            ctrl.reqIn = op inside {instrDecPkg::INN, instrDecPkg::P_INN}; // Port read
            ctrl.outEn = (op == instrDecPkg::OUT);                         // Port write
        end
    end

endmodule

`default_nettype wire

// ==== logic/opcodeMatch.sv ====
`default_nettype none
`include "instrDec_config.svh"

module opcodeMatch #(
    parameter logic [2**`ID_OPCODE_W-1:0] enableMask = `ID_ENABLE_MASK  // Bit n enables opcode n
) (
    input  wire [`ID_OPCODE_W-1:0] opcode,
    output instrDecPkg::decoded_t  decoded
);

    logic known;    // Opcode is part of the instruction set

    // ------------------------------
    // Instruction set membership
    // ------------------------------

    always_comb begin
        case (opcode)
            // Memory and indirect access
            instrDecPkg::LOD, instrDecPkg::P_LOD,
            instrDecPkg::LDI, instrDecPkg::ILI,
            instrDecPkg::SET, instrDecPkg::SET_P,
            instrDecPkg::STI, instrDecPkg::ISI:
                known = 1'b1;
            // Stack and I/O
            instrDecPkg::PSH, instrDecPkg::POP,
            instrDecPkg::INN, instrDecPkg::P_INN,
            instrDecPkg::OUT:
                known = 1'b1;
            // Two-operand arithmetic
            instrDecPkg::ADD, instrDecPkg::S_ADD,
            instrDecPkg::MLT, instrDecPkg::S_MLT,
            instrDecPkg::DIV, instrDecPkg::S_DIV,
            instrDecPkg::MOD, instrDecPkg::S_MOD,
            instrDecPkg::SGN, instrDecPkg::S_SGN:
                known = 1'b1;
            // One-operand arithmetic
            instrDecPkg::NEG, instrDecPkg::NEG_M, instrDecPkg::P_NEG_M,
            instrDecPkg::ABS, instrDecPkg::ABS_M, instrDecPkg::P_ABS_M,
            instrDecPkg::PST, instrDecPkg::PST_M, instrDecPkg::P_PST_M:
                known = 1'b1;
            // Bitwise
            instrDecPkg::AND, instrDecPkg::S_AND,
            instrDecPkg::ORR, instrDecPkg::S_ORR,
            instrDecPkg::XOR, instrDecPkg::S_XOR,
            instrDecPkg::INV, instrDecPkg::INV_M, instrDecPkg::P_INV_M:
                known = 1'b1;
            // Logical
            instrDecPkg::LAN, instrDecPkg::S_LAN,
            instrDecPkg::LOR, instrDecPkg::S_LOR,
            instrDecPkg::LIN, instrDecPkg::LIN_M, instrDecPkg::P_LIN_M:
                known = 1'b1;
            // Compare
            instrDecPkg::LES, instrDecPkg::S_LES,
            instrDecPkg::GRE, instrDecPkg::S_GRE,
            instrDecPkg::EQU, instrDecPkg::S_EQU:
                known = 1'b1;
            // Shift
            instrDecPkg::SHL, instrDecPkg::S_SHL,
            instrDecPkg::SHR, instrDecPkg::S_SHR,
            instrDecPkg::SRS, instrDecPkg::S_SRS:
                known = 1'b1;
            instrDecPkg::NOP:
                known = 1'b1;
            default:
                known = 1'b0;   // Jumps, float slots and empty space
        endcase
    end

    // ------------------------------
    // Decoded output
    // ------------------------------

    always_comb begin
        decoded.op    = instrDecPkg::opcode_e'(opcode);     // Passed on unconditionally
        decoded.valid = known && enableMask[opcode];        // Disabled looks unknown
        decoded.isNop = decoded.valid && (opcode == instrDecPkg::NOP);
    end

endmodule

`default_nettype wire

// ==== logic/instrDecPkg.sv ====
`default_nettype none
`include "instrDec_config.svh"

package instrDecPkg;

    // ------------------------------
    // Opcodes
    // ------------------------------

    typedef enum logic [`ID_OPCODE_W-1:0] {
        LOD   = 0,  P_LOD   = 1,                   // Load from data memory
        LDI   = 2,  ILI     = 3,                   // Indirect and bit-reversed indirect load
        SET   = 4,  SET_P   = 5,                   // Store, store with pop
        STI   = 6,  ISI     = 7,                   // Indirect and bit-reversed indirect store
        PSH   = 8,  POP     = 9,                   // Data stack
        INN   = 10, P_INN   = 11, OUT     = 12,    // I/O ports
        ADD   = 17, S_ADD   = 18,                  // Two-operand arithmetic
        MLT   = 21, S_MLT   = 22,
        DIV   = 25, S_DIV   = 26,
        MOD   = 29, S_MOD   = 30,
        SGN   = 31, S_SGN   = 32,
        NEG   = 35, NEG_M   = 36, P_NEG_M = 37,    // One-operand arithmetic
        ABS   = 41, ABS_M   = 42, P_ABS_M = 43,
        PST   = 47, PST_M   = 48, P_PST_M = 49,
        AND   = 62, S_AND   = 63,                  // Bitwise
        ORR   = 64, S_ORR   = 65,
        XOR   = 66, S_XOR   = 67,
        INV   = 68, INV_M   = 69, P_INV_M = 70,
        LAN   = 71, S_LAN   = 72,                  // Logical
        LOR   = 73, S_LOR   = 74,
        LIN   = 75, LIN_M   = 76, P_LIN_M = 77,
        LES   = 78, S_LES   = 79,                  // Compare
        GRE   = 82, S_GRE   = 83,
        EQU   = 86, S_EQU   = 87,
        SHL   = 88, S_SHL   = 89,                  // Shift
        SHR   = 90, S_SHR   = 91,
        SRS   = 92, S_SRS   = 93,
        NOP   = `ID_NOP_OPCODE
    } opcode_e;

    // ------------------------------
    // ALU operation codes
    // ------------------------------

    typedef enum logic [`ID_ALUOP_W-1:0] {
        ALU_NONE  = 0,                              // Accumulator untouched
        ALU_LOAD  = 1,                              // Accumulator takes operand
        ALU_ADD   = 2,  ALU_MLT   = 4,
        ALU_DIV   = 6,  ALU_MOD   = 8,
        ALU_SGN   = 9,                              // Sign of one operand onto the other
        ALU_NEG   = 11, ALU_NEG_M = 12,             // Two's complement
        ALU_ABS   = 15, ALU_ABS_M = 16,
        ALU_PST   = 19, ALU_PST_M = 20,             // Clamp negatives to zero
        ALU_AND   = 29, ALU_ORR   = 30, ALU_XOR   = 31,
        ALU_INV   = 32, ALU_INV_M = 33,
        ALU_LAN   = 34, ALU_LOR   = 35,
        ALU_LIN   = 36, ALU_LIN_M = 37,             // Logical not
        ALU_LES   = 38, ALU_GRE   = 40, ALU_EQU   = 42,
        ALU_SHL   = 43, ALU_SHR   = 44, ALU_SRS   = 45  // SRS keeps sign
    } aluOp_e;

    // ------------------------------
    // Decoder buses
    // ------------------------------

    typedef struct packed {
        opcode_e op;        // Raw opcode, meaningful only with valid
        logic    valid;     // Known and enabled
        logic    isNop;     // Enabled NOP
    } decoded_t;

    typedef struct packed {
        logic push;         // Push accumulator onto data stack
        logic pop;          // Pop data stack
        logic memWr;        // Data memory write
        logic reqIn;        // Input port request
        logic outEn;        // Output port enable
        logic ldi;          // Indirect load address
        logic sti;          // Indirect store address
        logic fft;          // Bit-reversed indirect address
    } ctrl_t;

endpackage

`default_nettype wire

// ==== logic/instrDec_config.svh ====
`ifndef INSTRDEC_CONFIG_SVH
`define INSTRDEC_CONFIG_SVH

// ------------------------------
// Widths
// ------------------------------

`define ID_OPCODE_W 7   // Opcode bits, 128 opcode slots
`define ID_ALUOP_W  6   // ALU operation code bits

// ------------------------------
// Special opcodes
// ------------------------------

`define ID_NOP_OPCODE 94    // No operation

// ------------------------------
// Instruction enables
// ------------------------------

// One bit per opcode slot, bit n enables opcode n
// Word 0 covers memory, stack, I/O and the integer ADD to SGN groups
// Word 1 covers NEG, ABS, PST and the first AND pair
// Word 2 covers the bitwise, logical, compare and shift groups plus NOP
// Word 3 is the unused top of the opcode space
// Jump, call and return slots 13 to 16 stay clear
// Float, normalise and conversion slots stay clear
`define ID_ENABLE_MASK 128'h00000000_7FCCFFFF_C0038E39_E6661FFF

// ------------------------------
// Pipeline behaviour
// ------------------------------

// 1 keeps the previous ALU code through a NOP
// 0 lets a NOP load ALU code 0
`define ID_HOLD_ON_NOP 1

`endif
